//--- ahb_decoder.sv
// ====================
// AHB-Lite address decoder
// Inclusive range compare per slave, default-slave select
// ====================

`default_nettype none
`timescale 1ns/10ps

module ahb_decoder #(
  parameter int addr_width = 32,
  parameter int slave_num = 2,
  parameter logic [slave_num-1:0][addr_width-1:0] low_addr = '0,
  parameter logic [slave_num-1:0][addr_width-1:0] high_addr = '0
) (
  input  logic [addr_width-1:0] haddr,
  input  ahb_pkg::htrans_type   htrans,
  output logic [slave_num-1:0]  hreq,
  output logic                  default_slv_sel
);

  // ====================
  // Region match
  // ====================

  // One bit per slave, set when haddr falls inside its region
  logic [slave_num-1:0] region_hit;
  // Only NONSEQ and SEQ carry a real transfer
  logic                 active;

  assign active = (htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ);

  // Both bounds inclusive, full address compared
  always_comb begin
    for (int i = 0; i < slave_num; i++) begin
      region_hit[i] = (haddr >= low_addr[i]) && (haddr <= high_addr[i]);
    end
  end

  // ====================
  // Requests
  // ====================

  // IDLE and BUSY select nobody
  assign hreq = active ? region_hit : '0;

  // Active transfer outside every region goes to the default slave
  assign default_slv_sel = active && !(|region_hit);

endmodule

`default_nettype wire

//--- ahb_default_slave.sv
// ====================
// AHB-Lite default slave
// Two-cycle ERROR answer for unmapped accesses
// ====================

`default_nettype none
`timescale 1ns/10ps

module ahb_default_slave (
  input  logic                hclk,
  input  logic                rst,
  input  logic                hsel,
  input  ahb_pkg::htrans_type htrans,
  input  logic                hready,
  output logic                hready_out,
  output ahb_pkg::hresp_type  hresp
);

  // Response sequencer states
  localparam logic [1:0] st_idle = 2'd0;
  // First ERROR cycle, wait inserted
  localparam logic [1:0] st_err1 = 2'd1;
  // Second ERROR cycle, data phase ends
  localparam logic [1:0] st_err2 = 2'd2;

  logic [1:0] state;
  logic       accept;

  // Address phase taken only with the bus ready and a real transfer
  assign accept = hsel && hready &&
                  ((htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ));

  // ====================
  // Sequencer
  // ====================

  always_ff @(posedge hclk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_err1: state <= st_err2;
        // Idle or last ERROR cycle, a new unmapped access may follow
        default: state <= accept ? st_err1 : st_idle;
      endcase
    end
  end

  // Low only in the first ERROR cycle
  assign hready_out = (state != st_err1);
  // Both ERROR cycles flag the error
  assign hresp = (state == st_idle) ? ahb_pkg::OKAY : ahb_pkg::ERROR;

endmodule

`default_nettype wire

//--- ahb_pkg.sv
// ====================
// AHB-Lite shared definitions
// Transfer types, response codes, data width
// ====================

`default_nettype none

package ahb_pkg;

  // ====================
  // Bus widths
  // ====================

  // Every transfer is one 32-bit word
  parameter int data_width = 32;

  // ====================
  // Transfer type
  // ====================

  // Encoding as on the htrans bus
  typedef enum logic [1:0] {
    // No transfer wanted
    IDLE   = 2'b00,
    // Master inserts a gap inside a burst
    BUSY   = 2'b01,
    // First beat or single transfer
    NONSEQ = 2'b10,
    // Following beat of a burst
    SEQ    = 2'b11
  } htrans_type;

  // ====================
  // Slave response
  // ====================

  // AHB-Lite has OKAY and ERROR only
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_type;

endpackage

`default_nettype wire

//--- ahb_resp_mux.sv
// ====================
// AHB-Lite response multiplexer
// Data-phase owner tracking, hrdata/hready/hresp select
// ====================

`default_nettype none
`timescale 1ns/10ps

module ahb_resp_mux #(
  parameter int slave_num = 2
) (
  input  logic                                          hclk,
  input  logic                                          rst,
  input  logic [slave_num-1:0]                          hreq,
  input  logic                                          default_slv_sel,
  input  logic [slave_num-1:0][ahb_pkg::data_width-1:0] slv_hrdata,
  input  logic [slave_num-1:0]                          slv_hready,
  input  ahb_pkg::hresp_type [slave_num-1:0]            slv_hresp,
  input  logic                                          def_hready,
  input  ahb_pkg::hresp_type                            def_hresp,
  output logic [ahb_pkg::data_width-1:0]                hrdata,
  output logic                                          hready,
  output ahb_pkg::hresp_type                            hresp
);

  localparam int idx_w = (slave_num > 1) ? $clog2(slave_num) : 1;

  // Encoded address-phase request
  logic [idx_w-1:0] req_idx;
  // Data-phase owner
  logic [idx_w-1:0] own_idx;
  logic             own_slv;
  logic             own_def;

  // hreq is one-hot, so a plain priority scan suffices
  always_comb begin
    req_idx = '0;
    for (int i = 0; i < slave_num; i++) begin
      if (hreq[i]) begin
        req_idx = idx_w'(i);
      end
    end
  end

  // Owner moves only when the current data phase ends
  always_ff @(posedge hclk) begin
    if (rst) begin
      own_slv <= 1'b0;
      own_def <= 1'b0;
      own_idx <= '0;
    end else if (hready) begin
      own_slv <= |hreq;
      own_def <= default_slv_sel;
      own_idx <= req_idx;
    end
  end

  // ====================
  // Return path
  // ====================

  always_comb begin
    if (own_def) begin
      hrdata = '0;
      hready = def_hready;
      hresp  = def_hresp;
    end else if (own_slv) begin
      hrdata = slv_hrdata[own_idx];
      hready = slv_hready[own_idx];
      hresp  = slv_hresp[own_idx];
    end else begin
      // Nobody owns it, zero-wait OKAY
      hrdata = '0;
      hready = 1'b1;
      hresp  = ahb_pkg::OKAY;
    end
  end

endmodule

`default_nettype wire

//--- ahb_sram_slave.sv
// ====================
// AHB-Lite SRAM slave
// Word-wide memory, fixed number of wait states
// ====================

`default_nettype none
`timescale 1ns/10ps

module ahb_sram_slave #(
  parameter int addr_width = 32,
  parameter int mem_words = 4096,
  parameter int wait_states = 0
) (
  input  logic                             hclk,
  input  logic                             rst,
  input  logic                             hsel,
  input  logic [addr_width-1:0]            haddr,
  input  ahb_pkg::htrans_type              htrans,
  input  logic                             hwrite,
  input  logic [ahb_pkg::data_width-1:0]   hwdata,
  input  logic                             hready,
  output logic                             hready_out,
  output ahb_pkg::hresp_type               hresp,
  output logic [ahb_pkg::data_width-1:0]   hrdata
);

  // Word index width, mem_words is a power of two
  localparam int idx_w = $clog2(mem_words);
  // Wide enough for wait_states, at least one bit
  localparam int cnt_w = $clog2(wait_states + 2);

  // ====================
  // Storage and state
  // ====================

  logic [ahb_pkg::data_width-1:0] mem [mem_words];

  // Latched address phase
  logic [idx_w-1:0] idx_q;
  logic             wr_q;
  // Data phase in progress
  logic             pending;
  // Wait cycles still to insert
  logic [cnt_w-1:0] cnt;

  logic accept;
  logic data_end;

  assign accept = hsel && hready &&
                  ((htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ));

  // Shared hready is ours while we own the data phase
  assign data_end = pending && hready;

  // ====================
  // Control
  // ====================

  always_ff @(posedge hclk) begin
    if (rst) begin
      pending <= 1'b0;
      wr_q    <= 1'b0;
      cnt     <= '0;
    end else begin
      if (accept) begin
        pending <= 1'b1;
        wr_q    <= hwrite;
        cnt     <= cnt_w'(wait_states);
      end else if (data_end) begin
        pending <= 1'b0;
      end else if (pending && (cnt != '0)) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Word index, upper address bits wrap modulo the depth
  always_ff @(posedge hclk) begin
    if (accept) begin
      idx_q <= haddr[2 +: idx_w];
    end
  end

  // Write lands on the edge closing the data phase
  always_ff @(posedge hclk) begin
    if (data_end && wr_q) begin
      mem[idx_q] <= hwdata;
    end
  end

  // ====================
  // Response
  // ====================

  assign hready_out = !pending || (cnt == '0);
  assign hresp      = ahb_pkg::OKAY;
  // Read word sampled by the master when hready goes high
  assign hrdata     = mem[idx_q];

endmodule

`default_nettype wire

//--- ahb_subsys_chk.sv
// ====================
// AHB-Lite response protocol checker
// Request one-hot, ERROR sequence, state after reset
// ====================

`default_nettype none
`timescale 1ns/10ps

module ahb_subsys_chk #(
  parameter int slave_num = 2
) (
  input logic                 hclk,
  input logic                 rst,
  input logic [slave_num-1:0] hreq,
  input logic                 default_slv_sel,
  input logic                 hready,
  input ahb_pkg::hresp_type   hresp
);

  // Number of assertion failures so far
  int assert_failures = 0;

  // At most one slave or the default slave selected
  a_req_onehot: assert property (@(posedge hclk) disable iff (rst)
    $onehot0({hreq, default_slv_sel}))
    else begin
      $error("slave requests not one-hot");
      assert_failures++;
    end

  // First ERROR cycle waits and the second one completes
  a_err_seq: assert property (@(posedge hclk) disable iff (rst)
    (hresp == ahb_pkg::ERROR && !hready) |=> (hresp == ahb_pkg::ERROR && hready))
    else begin
      $error("ERROR response not followed by its completing cycle");
      assert_failures++;
    end

  // Bus idle and ready right after reset
  a_reset_exit: assert property (@(posedge hclk)
    $fell(rst) |-> (hready && hresp == ahb_pkg::OKAY))
    else begin
      $error("bus not ready with OKAY after reset");
      assert_failures++;
    end

endmodule

bind ahb_subsys_top ahb_subsys_chk #(.slave_num(2)) ahb_subsys_chk_i (
  .hclk(hclk), .rst(rst), .hreq(hreq), .default_slv_sel(default_slv_sel),
  .hready(hready), .hresp(hresp)
);

`default_nettype wire

//--- ahb_subsys_top.sv
// ====================
// AHB-Lite slave subsystem top
// Decoder, two SRAM slaves, default slave, response mux
// ====================

`default_nettype none
`timescale 1ns/10ps

module ahb_subsys_top #(
  parameter int addr_width = 32
) (
  input  logic                           hclk,
  input  logic                           rst,
  input  logic [addr_width-1:0]          haddr,
  input  ahb_pkg::htrans_type            htrans,
  input  logic                           hwrite,
  input  logic [ahb_pkg::data_width-1:0] hwdata,
  output logic [ahb_pkg::data_width-1:0] hrdata,
  output logic                           hready,
  output ahb_pkg::hresp_type             hresp
);

  // ====================
  // Address map
  // ====================

  localparam int slave_num = 2;

  // Slave 0 at 0x8000..0xFFFF, slave 1 at 0x1_0000..0x1_3FFF
  localparam logic [slave_num-1:0][addr_width-1:0] low_addr =
    {addr_width'(32'h0001_0000), addr_width'(32'h0000_8000)};
  localparam logic [slave_num-1:0][addr_width-1:0] high_addr =
    {addr_width'(32'h0001_3FFF), addr_width'(32'h0000_FFFF)};

  logic [slave_num-1:0]                          hreq;
  logic                                          default_slv_sel;
  logic [slave_num-1:0][ahb_pkg::data_width-1:0] slv_hrdata;
  logic [slave_num-1:0]                          slv_hready;
  ahb_pkg::hresp_type [slave_num-1:0]            slv_hresp;
  logic                                          def_hready;
  ahb_pkg::hresp_type                            def_hresp;

  ahb_decoder #(
    .addr_width(addr_width), .slave_num(slave_num),
    .low_addr(low_addr), .high_addr(high_addr)
  ) ahb_decoder_i (
    .haddr(haddr), .htrans(htrans), .hreq(hreq), .default_slv_sel(default_slv_sel)
  );

  // 32 KB, zero wait
  ahb_sram_slave #(
    .addr_width(addr_width), .mem_words(8192), .wait_states(0)
  ) ahb_sram_slave_0_i (
    .hclk(hclk), .rst(rst), .hsel(hreq[0]), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .hready_out(slv_hready[0]), .hresp(slv_hresp[0]), .hrdata(slv_hrdata[0])
  );

  // 16 KB, two waits
  ahb_sram_slave #(
    .addr_width(addr_width), .mem_words(4096), .wait_states(2)
  ) ahb_sram_slave_1_i (
    .hclk(hclk), .rst(rst), .hsel(hreq[1]), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .hready_out(slv_hready[1]), .hresp(slv_hresp[1]), .hrdata(slv_hrdata[1])
  );

  ahb_default_slave ahb_default_slave_i (
    .hclk(hclk), .rst(rst), .hsel(default_slv_sel), .htrans(htrans),
    .hready(hready), .hready_out(def_hready), .hresp(def_hresp)
  );

  ahb_resp_mux #(
    .slave_num(slave_num)
  ) ahb_resp_mux_i (
    .hclk(hclk), .rst(rst), .hreq(hreq), .default_slv_sel(default_slv_sel),
    .slv_hrdata(slv_hrdata), .slv_hready(slv_hready), .slv_hresp(slv_hresp),
    .def_hready(def_hready), .def_hresp(def_hresp),
    .hrdata(hrdata), .hready(hready), .hresp(hresp)
  );

endmodule

`default_nettype wire

//--- build.f
ahb_pkg.sv
ahb_decoder.sv
ahb_default_slave.sv
ahb_sram_slave.sv
ahb_resp_mux.sv
ahb_subsys_top.sv
ahb_subsys_chk.sv
tb_ahb_subsys.sv

//--- tb_ahb_subsys.sv
// ====================
// Directed testbench for the AHB-Lite slave subsystem
// Clock, reset, bus transfer task, reference memory, reporting
// ====================

`default_nettype none
`timescale 1ns/10ps

module tb_ahb_subsys;

  localparam int max_wait = 50;

  logic                           hclk;
  logic                           rst;
  logic [31:0]                    haddr;
  ahb_pkg::htrans_type            htrans;
  logic                           hwrite;
  logic [ahb_pkg::data_width-1:0] hwdata;
  logic [ahb_pkg::data_width-1:0] hrdata;
  logic                           hready;
  ahb_pkg::hresp_type             hresp;

  // Expected word per mapped byte address
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] lcg_state = 32'hf377_c173;
  int          errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          chk_failures;

  ahb_subsys_top ahb_subsys_top_i (
    .hclk(hclk), .rst(rst), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
    .hwdata(hwdata), .hrdata(hrdata), .hready(hready), .hresp(hresp)
  );

  initial begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;
  end

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Region index by the inclusive address map or -1 when unmapped
  function automatic int region_of(input logic [31:0] addr);
    if (addr >= 32'h0000_8000 && addr <= 32'h0000_FFFF) return 0;
    if (addr >= 32'h0001_0000 && addr <= 32'h0001_3FFF) return 1;
    return -1;
  endfunction

  task automatic check_that(input bit ok, input string msg);
    assert (ok) else begin
      $display("FAILED at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic hang_abort(input string where);
    $display("Timeout: hready stayed low too long during the %s", where);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_count++;
      $display("Test %s: pass", name);
    end else begin
      fail_count++;
      $display("Test %s: fail with %0d errors", name, errors - err_before);
    end
  endtask

  // One transfer followed by IDLE with its wait and ERROR cycle counts
  task automatic bus_transfer(input ahb_pkg::htrans_type trans, input logic write,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int waits,
                              output int err_cycles);
    int guard;
    guard = 0;
    waits = 0;
    err_cycles = 0;
    @(negedge hclk);
    haddr  = addr;
    htrans = trans;
    hwrite = write;
    while (!hready) begin
      guard++;
      if (guard > max_wait) hang_abort("address phase");
      @(negedge hclk);
    end
    // Data phase starts here
    @(negedge hclk);
    htrans = ahb_pkg::IDLE;
    hwrite = 1'b0;
    hwdata = wdata;
    guard  = 0;
    while (!hready) begin
      if (hresp == ahb_pkg::ERROR) err_cycles++;
      waits++;
      guard++;
      if (guard > max_wait) hang_abort("data phase");
      @(negedge hclk);
    end
    if (hresp == ahb_pkg::ERROR) err_cycles++;
    rdata = hrdata;
  endtask

  // Transfer plus comparison against the map rules and the reference memory
  task automatic xfer_and_compare(input ahb_pkg::htrans_type trans, input logic write,
                                  input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    int          waits;
    int          errs;
    int          region;
    int          exp_waits;
    int          exp_errs;
    bit          active;
    bus_transfer(trans, write, addr, wdata, rdata, waits, errs);
    active = (trans == ahb_pkg::NONSEQ) || (trans == ahb_pkg::SEQ);
    region = region_of(addr);
    // Zero waits on slave 0, two on slave 1 and one on the default slave
    exp_waits = !active ? 0 : (region == 0) ? 0 : (region == 1) ? 2 : 1;
    exp_errs  = (active && region < 0) ? 2 : 0;
    check_that(waits == exp_waits, $sformatf("addr %h: %0d wait cycles, expected %0d",
                                             addr, waits, exp_waits));
    check_that(errs == exp_errs, $sformatf("addr %h: %0d ERROR cycles, expected %0d",
                                           addr, errs, exp_errs));
    if (active && region >= 0) begin
      if (write) begin
        ref_mem[addr] = wdata;
      end else if (ref_mem.exists(addr)) begin
        check_that(rdata === ref_mem[addr], $sformatf("addr %h: read %h, expected %h",
                                                      addr, rdata, ref_mem[addr]));
      end
    end
  endtask

  // ====================
  // Tests
  // ====================

  task automatic slave0_write_read();
    logic [31:0] addrs [4] = '{32'h8010, 32'h8A04, 32'hC000, 32'hF0F0};
    int          err_before;
    err_before = errors;
    foreach (addrs[i]) xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, addrs[i], next_rand());
    foreach (addrs[i]) xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, addrs[i], '0);
    finish_test("slave0_rw", err_before);
  endtask

  task automatic slave1_wait_states();
    logic [31:0] addrs [3] = '{32'h1_0004, 32'h1_2340, 32'h1_3000};
    int          err_before;
    err_before = errors;
    foreach (addrs[i]) xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, addrs[i], next_rand());
    foreach (addrs[i]) xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, addrs[i], '0);
    finish_test("slave1_waits", err_before);
  endtask

  task automatic unmapped_error();
    int err_before;
    err_before = errors;
    // Word index 0 in each SRAM, the alias of both unmapped addresses
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, 32'h0000_8000, next_rand());
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, 32'h0001_0000, next_rand());
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, 32'h0000_0000, 32'hdead_beef);
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, 32'h0002_0000, 32'hcafe_f00d);
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, 32'h0002_0000, '0);
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, 32'h0000_0000, '0);
    // Aliased words still hold their old data
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, 32'h0000_8000, '0);
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, 32'h0001_0000, '0);
    finish_test("unmapped_error", err_before);
  endtask

  task automatic idle_busy_no_write();
    int err_before;
    err_before = errors;
    xfer_and_compare(ahb_pkg::IDLE, 1'b1, 32'h8010, 32'h1111_2222);
    xfer_and_compare(ahb_pkg::BUSY, 1'b1, 32'h1_0004, 32'h3333_4444);
    xfer_and_compare(ahb_pkg::BUSY, 1'b1, 32'h0000_0000, 32'h5555_6666);
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, 32'h8010, '0);
    xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, 32'h1_0004, '0);
    finish_test("idle_busy", err_before);
  endtask

  task automatic address_boundaries();
    logic [31:0] addrs [6] = '{32'h8000, 32'hFFFC, 32'h1_0000, 32'h1_3FFC,
                               32'h7FFC, 32'h1_4000};
    int          err_before;
    err_before = errors;
    foreach (addrs[i]) xfer_and_compare(ahb_pkg::NONSEQ, 1'b1, addrs[i], next_rand());
    foreach (addrs[i]) xfer_and_compare(ahb_pkg::NONSEQ, 1'b0, addrs[i], '0);
    finish_test("boundaries", err_before);
  endtask

  task automatic random_transfers();
    logic [31:0] r;
    logic [31:0] addr;
    logic        write;
    int          err_before;
    err_before = errors;
    repeat (40) begin
      r = next_rand();
      case (r % 3)
        0: addr = 32'h8000 + ((r >> 8) & 32'h7FFC);
        1: addr = 32'h1_0000 + ((r >> 8) & 32'h3FFC);
        default: addr = r[20] ? 32'h2_0000 + ((r >> 8) & 32'hFFFC)
                              : ((r >> 8) & 32'h7FFC);
      endcase
      // Reads only where the model knows the word
      write = r[4] || (region_of(addr) >= 0 && !ref_mem.exists(addr));
      xfer_and_compare(ahb_pkg::NONSEQ, write, addr, next_rand());
    end
    finish_test("random", err_before);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    rst    = 1'b1;
    haddr  = '0;
    htrans = ahb_pkg::IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    repeat (10) @(posedge hclk);
    @(negedge hclk);
    rst = 1'b0;
    slave0_write_read();
    slave1_wait_states();
    unmapped_error();
    idle_busy_no_write();
    address_boundaries();
    random_transfers();
    chk_failures = ahb_subsys_top_i.ahb_subsys_chk_i.assert_failures;
    $display("Tests passed: %0d, failed: %0d, protocol assertion failures: %0d",
             pass_count, fail_count, chk_failures);
    if (fail_count == 0 && errors == 0 && chk_failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
